// File: vlog.f
+incdir+hw
hw/lcd_pkg.sv
hw/lcd_cmd_fifo.sv
hw/lcd_init_rom.sv
hw/lcd_seq.sv
hw/lcd_spi_tx.sv
hw/lcd_hvline_top.sv
dv/lcd_tb_props.sv
dv/lcd_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ST7789 line engine testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module lcd_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/Vlcd_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: dv/lcd_tb.sv
// Testbench for the ST7789 line engine
// random h/v lines through the queue, SPI bytes decoded and compared to a model
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_tb
  import lcd_pkg::*;
();

  localparam int NCMD = 8; // single pixel, h, v, then a burst of five
  localparam int DELAY_CLKS = `LCD_DELAY_UNIT << 3; // SWRESET and SLPOUT wait 2^3 steps

  typedef logic [8:0] word_t; // {data, dc}
  typedef word_t word_q_t[$];

  logic      clk = 1'b0;
  logic      reset;
  logic      cmd_valid;
  line_cmd_t cmd;
  logic      cmd_ready;
  logic      idle;
  logic      spi_clk;
  logic      spi_mosi;
  logic      spi_dc;
  logic      spi_csn;
  logic      spi_resn;

  logic [31:0] lfsr = 32'hf47b;
  word_q_t     exp_q;            // words still owed by the DUT
  word_q_t     got_q;            // decoded, not yet compared
  line_cmd_t   cmds [NCMD];
  int          gaps [NCMD];
  int          cycles = 0;
  int          limit = 1000000;  // replaced once the commands are planned
  logic        saw_full = 1'b0;
  logic        prev_sclk = 1'b1;
  logic [7:0]  shift_in = '0;
  int          nbits = 0;
  int          hi_len = 0;       // clocks with spi_csn high since the last byte
  int          nwords = 0;       // words decoded so far

  always #4 clk = ~clk; // 8 ns period

  lcd_hvline_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .idle      (idle),
    .spi_clk   (spi_clk),
    .spi_mosi  (spi_mosi),
    .spi_dc    (spi_dc),
    .spi_csn   (spi_csn),
    .spi_resn  (spi_resn)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr); // one step per bit
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic line_cmd_t random_cmd();
    line_cmd_t c;
    c.x        = coord_t'(rand_bits(8) % 240);
    c.y        = coord_t'(rand_bits(8) % 240);
    c.len      = coord_t'(rand_bits(4) % 9); // 0..8
    c.color    = color_t'(rand_bits(16));
    c.vertical = (rand_bits(1) != 0);
    return c;
  endfunction

  // expected serial words for one line command
  function automatic word_q_t line_words(input line_cmd_t c);
    word_q_t w;
    coord_t  xe;
    coord_t  ye;
    xe = c.vertical ? c.x : coord_t'(c.x + c.len - 1);
    ye = c.vertical ? coord_t'(c.y + c.len - 1) : c.y;
    if (c.len == 0) return w; // dropped with nothing on the wire
    w.push_back({`LCD_CMD_CASET, 1'b0});
    w.push_back({c.x[15:8], 1'b1});
    w.push_back({c.x[7:0], 1'b1});
    w.push_back({xe[15:8], 1'b1});
    w.push_back({xe[7:0], 1'b1});
    w.push_back({`LCD_CMD_RASET, 1'b0});
    w.push_back({c.y[15:8], 1'b1});
    w.push_back({c.y[7:0], 1'b1});
    w.push_back({ye[15:8], 1'b1});
    w.push_back({ye[7:0], 1'b1});
    w.push_back({`LCD_CMD_RAMWR, 1'b0});
    for (int i = 0; i < c.len; i++) begin
      w.push_back({c.color[15:8], 1'b1}); // msb first
      w.push_back({c.color[7:0], 1'b1});
    end
    return w;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // offer one command and log its words once the queue takes it
  task automatic send_cmd(input line_cmd_t c, input int gap);
    word_q_t w;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    cmd_valid = 1'b1;
    cmd       = c;
    @(negedge clk);
    while (cmd_ready !== 1'b1) begin
      saw_full = 1'b1; // queue full, caller stalls
      @(negedge clk);
    end
    w = line_words(c);
    foreach (w[i]) exp_q.push_back(w[i]);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  // SPI decoder samples each spi_clk rise inside a byte at mid-cycle
  always @(negedge clk) begin
    if (spi_csn === 1'b1) begin
      hi_len = hi_len + 1;
    end else if (spi_csn === 1'b0 && hi_len != 0) begin
      if (nwords == 1 || nwords == 2) begin // gaps after SWRESET and SLPOUT
        check_eq(hi_len >= DELAY_CLKS, 1, "byte sent inside a start-up delay");
      end
      hi_len = 0;
    end
    if (spi_csn === 1'b0 && spi_clk && !prev_sclk) begin
      shift_in = {shift_in[6:0], spi_mosi};
      nbits    = nbits + 1;
      if (nbits == 8) begin
        got_q.push_back({shift_in, spi_dc});
        nwords = nwords + 1;
        nbits  = 0;
      end
    end
    prev_sclk = spi_clk;
    if (idle === 1'b1 && !cmd_valid) check_eq(exp_q.size(), 0, "idle with words still owed");
  end

  // compare process
  always @(posedge clk) begin : compare
    word_t got_w;
    word_t exp_w;
    while (got_q.size() != 0) begin
      got_w = got_q.pop_front();
      check_eq(exp_q.size() != 0, 1, "word decoded with none expected");
      exp_w = exp_q.pop_front();
      check_eq(got_w, exp_w, "spi word {data,dc}");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", limit);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin : main
    int pixels;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    pixels    = 0;
    for (int i = 0; i < NCMD; i++) cmds[i] = random_cmd();
    cmds[0].len      = 16'd1;                              // single pixel
    cmds[1].vertical = 1'b0;
    cmds[1].len      = coord_t'(rand_bits(3) + 1);         // 1..8
    cmds[2].vertical = 1'b1;
    cmds[2].len      = coord_t'(rand_bits(3) + 1);
    cmds[5].len      = 16'd0;                              // consumed, no bytes
    for (int i = 0; i < NCMD; i++) begin
      gaps[i] = (i < 3) ? int'(rand_bits(2)) : 0; // burst goes back to back
      pixels += int'(cmds[i].len);
    end
    limit = `LCD_RESET_CYCLES + 2000 + 40 * pixels;

    // start-up table as sent on the wire
    exp_q.push_back({8'h01, 1'b0});
    exp_q.push_back({8'h11, 1'b0});
    exp_q.push_back({8'h3A, 1'b0});
    exp_q.push_back({8'h55, 1'b1});
    exp_q.push_back({8'h36, 1'b0});
    exp_q.push_back({8'h00, 1'b1});
    exp_q.push_back({8'h29, 1'b0});

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (`LCD_RESET_CYCLES) begin
      @(negedge clk);
      check_eq(spi_resn, 0, "spi_resn during reset hold");
      check_eq(spi_csn, 1, "spi_csn during reset hold");
    end
    @(negedge clk);
    check_eq(spi_resn, 1, "spi_resn after reset hold");

    @(posedge clk);
    #1;
    for (int i = 0; i < NCMD; i++) send_cmd(cmds[i], gaps[i]);

    while (idle !== 1'b1) @(negedge clk);
    repeat (40) @(negedge clk); // room for any stray byte to show up
    check_eq(exp_q.size(), 0, "words never sent");
    check_eq(got_q.size(), 0, "words left uncompared");
    check_eq(idle, 1, "idle at end");
    check_eq(saw_full, 1, "cmd_ready never fell during the burst");
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/lcd_tb_props.sv
// Bound checks for the line engine
// command handshake, chip select framing and panel reset
`timescale 1ns/1ps
`default_nettype none

module lcd_tb_props
  import lcd_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      cmd_valid,
  input line_cmd_t cmd,
  input logic      cmd_ready,
  input logic      spi_csn,
  input logic      spi_dc,
  input logic      spi_resn
);

  logic [7:0] low_len; // clocks with spi_csn low in the current byte

  always_ff @(posedge clk) begin
    if (reset || spi_csn) low_len <= '0;
    else low_len <= low_len + 1'b1;
  end

  stall_hold: assert property (@(posedge clk) disable iff (reset)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd)) // caller holds a stalled cmd
    else $error("cmd changed while cmd_ready was low");

  csn_frame: assert property (@(posedge clk) disable iff (reset)
    $rose(spi_csn) |-> low_len == 8'd16) // one byte is 16 clocks
    else $error("spi_csn low for %0d clocks", low_len);

  dc_hold: assert property (@(posedge clk) disable iff (reset)
    !spi_csn && !$past(spi_csn) |-> $stable(spi_dc))
    else $error("spi_dc changed inside a byte");

  resn_quiet: assert property (@(posedge clk) disable iff (reset)
    !spi_resn |-> spi_csn) // panel in reset sees no traffic
    else $error("spi_csn low while spi_resn low");

endmodule

bind lcd_hvline_top lcd_tb_props props0 (
  .clk       (clk),
  .reset     (reset),
  .cmd_valid (cmd_valid),
  .cmd       (cmd),
  .cmd_ready (cmd_ready),
  .spi_csn   (spi_csn),
  .spi_dc    (spi_dc),
  .spi_resn  (spi_resn)
);

`default_nettype wire

// File: hw/lcd_hvline_top.sv
// ST7789 horizontal/vertical line engine
// command queue, start-up rom, sequencer and SPI serializer
`timescale 1ns/1ps
`default_nettype none

module lcd_hvline_top
  import lcd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      cmd_valid,
  input  line_cmd_t cmd,
  output logic      cmd_ready,
  output logic      idle,
  output logic      spi_clk,
  output logic      spi_mosi,
  output logic      spi_dc,
  output logic      spi_csn,
  output logic      spi_resn
);

  logic       q_valid;
  line_cmd_t  q_cmd;
  logic       q_ready;
  logic       fifo_empty;
  logic [3:0] rom_addr;
  lcd_byte_t  rom_data;
  logic       byte_valid;
  spi_word_t  byte_out;
  logic       byte_ready;
  logic       seq_idle;
  logic       tx_idle;

  assign idle = fifo_empty & seq_idle & tx_idle; // all drained

  lcd_cmd_fifo #(
    .DEPTH(4)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .q_valid   (q_valid),
    .q_cmd     (q_cmd),
    .q_ready   (q_ready),
    .empty     (fifo_empty)
  );

  lcd_init_rom u_rom (
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  lcd_seq u_seq (
    .clk        (clk),
    .reset      (reset),
    .q_valid    (q_valid),
    .q_cmd      (q_cmd),
    .q_ready    (q_ready),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .byte_valid (byte_valid),
    .byte_out   (byte_out),
    .byte_ready (byte_ready),
    .spi_resn   (spi_resn),
    .seq_idle   (seq_idle)
  );

  lcd_spi_tx u_tx (
    .clk        (clk),
    .reset      (reset),
    .byte_valid (byte_valid),
    .byte_in    (byte_out),
    .byte_ready (byte_ready),
    .spi_clk    (spi_clk),
    .spi_mosi   (spi_mosi),
    .spi_dc     (spi_dc),
    .spi_csn    (spi_csn),
    .tx_idle    (tx_idle)
  );

endmodule

`default_nettype wire

// File: hw/lcd_spi_tx.sv
// SPI byte serializer
// mode 3 style clock (idle high, data changes on the falling edge),
// msb first, 16 clocks per byte with chip select low only for the byte
`timescale 1ns/1ps
`default_nettype none

module lcd_spi_tx
  import lcd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      byte_valid,
  input  spi_word_t byte_in,
  output logic      byte_ready,
  output logic      spi_clk,
  output logic      spi_mosi,
  output logic      spi_dc,
  output logic      spi_csn,
  output logic      tx_idle
);

  logic       busy;  // shifting a byte
  logic       gap;   // idle clock after a byte
  logic [3:0] cnt;   // bit index in [3:1], half-bit phase in [0]
  lcd_byte_t  shreg;
  logic       dc_q;
  logic       accept;

  assign accept     = byte_valid & byte_ready;
  assign byte_ready = ~busy & ~gap;   // shifter empty
  assign spi_clk    = ~busy | cnt[0]; // low in first half of each bit
  assign spi_mosi   = shreg[7];
  assign spi_dc     = dc_q;
  assign spi_csn    = ~busy;
  assign tx_idle    = ~busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      gap  <= 1'b0;
      cnt  <= '0;
      dc_q <= 1'b0;
    end else begin
      gap <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        cnt  <= '0;
        dc_q <= byte_in.dc; // held for the whole byte
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == 4'd15) begin
          busy <= 1'b0;
          gap  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) shreg <= byte_in.data;
    else if (busy && cnt[0]) shreg <= {shreg[6:0], 1'b0}; // next bit on falling edge
  end

endmodule

`default_nettype wire

// File: hw/lcd_seq.sv
// ST7789 sequencer
// holds the panel in reset, plays the start-up table with its delays,
// then turns each line command into window bytes and a color stream
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_seq
  import lcd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       q_valid,
  input  line_cmd_t  q_cmd,
  output logic       q_ready,
  output logic [3:0] rom_addr,
  input  lcd_byte_t  rom_data,
  output logic       byte_valid,
  output spi_word_t  byte_out,
  input  logic       byte_ready,
  output logic       spi_resn,
  output logic       seq_idle
);

  seq_state_t  state;
  logic [19:0] delay_cnt; // reset hold and rom delays share it
  logic        armed;     // delay count loaded
  logic [3:0]  num_args;  // args left in current entry
  logic        delay_set; // entry ends with a delay
  logic [3:0]  byte_idx;  // window byte 0..10
  logic        toggle;    // 0 color msb, 1 color lsb
  line_cmd_t   cmd_r;
  coord_t      x_end;
  coord_t      y_end;
  coord_t      pix_cnt;   // pixels left
  logic        xfer;
  logic        rom_end;

  assign xfer     = byte_valid & byte_ready;
  assign rom_end  = (rom_addr == 4'(`LCD_ROM_SIZE));
  assign q_ready  = (state == S_IDLE);
  assign seq_idle = (state == S_IDLE);

  // control path
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_RESET_WAIT;
      delay_cnt <= 20'(`LCD_RESET_CYCLES - 1);
      armed     <= 1'b0;
      rom_addr  <= '0;
      byte_idx  <= '0;
      toggle    <= 1'b0;
      spi_resn  <= 1'b0;
    end else begin
      case (state)
        S_RESET_WAIT: begin
          if (delay_cnt == '0) begin
            spi_resn <= 1'b1; // release panel
            state    <= S_INIT_CMD;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        S_INIT_CMD: begin
          if (rom_end) begin
            state <= S_IDLE; // table done
          end else if (xfer) begin
            rom_addr <= rom_addr + 1'b1;
            state    <= S_INIT_FLAGS;
          end
        end
        S_INIT_FLAGS: begin
          rom_addr <= rom_addr + 1'b1;
          if (rom_data[3:0] != '0) state <= S_INIT_ARG;
          else if (rom_data[7]) state <= S_INIT_DELAY;
          else state <= S_INIT_CMD;
        end
        S_INIT_ARG: begin
          if (xfer) begin
            rom_addr <= rom_addr + 1'b1;
            if (num_args == 4'd1) state <= delay_set ? S_INIT_DELAY : S_INIT_CMD;
          end
        end
        S_INIT_DELAY: begin
          if (!armed) begin
            if (byte_ready) begin // last byte fully shifted out
              delay_cnt <= (20'(`LCD_DELAY_UNIT) << rom_data[3:0]) - 20'd1;
              armed     <= 1'b1;
              rom_addr  <= rom_addr + 1'b1; // skip exponent byte
            end
          end else if (delay_cnt == '0) begin
            armed <= 1'b0;
            state <= S_INIT_CMD;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        S_IDLE: begin
          if (q_valid && q_cmd.len != '0) begin // len 0 popped and dropped
            byte_idx <= '0;
            toggle   <= 1'b0;
            state    <= S_WINDOW;
          end
        end
        S_WINDOW: begin
          if (xfer) begin
            if (byte_idx == 4'd10) state <= S_PIXELS; // ramwr sent
            else byte_idx <= byte_idx + 1'b1;
          end
        end
        S_PIXELS: begin
          if (xfer) begin
            toggle <= ~toggle;
            if (toggle && pix_cnt == 16'd1) state <= S_IDLE; // last lsb
          end
        end
        default: state <= S_RESET_WAIT;
      endcase
    end
  end

  // line and table payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && q_valid) begin
      cmd_r   <= q_cmd;
      pix_cnt <= q_cmd.len;
      x_end   <= q_cmd.vertical ? q_cmd.x : q_cmd.x + q_cmd.len - 16'd1;
      y_end   <= q_cmd.vertical ? q_cmd.y + q_cmd.len - 16'd1 : q_cmd.y;
    end
    if (state == S_INIT_FLAGS) begin
      num_args  <= rom_data[3:0];
      delay_set <= rom_data[7];
    end
    if (state == S_INIT_ARG && xfer) num_args <= num_args - 1'b1;
    if (state == S_PIXELS && xfer && toggle) pix_cnt <= pix_cnt - 1'b1;
  end

  // byte presented to the serializer and held until accepted
  always_comb begin
    byte_valid    = 1'b0;
    byte_out.data = `LCD_CMD_NOP;
    byte_out.dc   = 1'b0;
    case (state)
      S_INIT_CMD: begin
        byte_valid    = ~rom_end;
        byte_out.data = rom_data;
      end
      S_INIT_ARG: begin
        byte_valid    = 1'b1;
        byte_out.data = rom_data;
        byte_out.dc   = 1'b1;
      end
      S_WINDOW: begin
        byte_valid  = 1'b1;
        byte_out.dc = 1'b1; // cleared below for the three commands
        case (byte_idx)
          4'd0: begin
            byte_out.data = `LCD_CMD_CASET;
            byte_out.dc   = 1'b0;
          end
          4'd1:    byte_out.data = cmd_r.x[15:8];
          4'd2:    byte_out.data = cmd_r.x[7:0];
          4'd3:    byte_out.data = x_end[15:8];
          4'd4:    byte_out.data = x_end[7:0];
          4'd5: begin
            byte_out.data = `LCD_CMD_RASET;
            byte_out.dc   = 1'b0;
          end
          4'd6:    byte_out.data = cmd_r.y[15:8];
          4'd7:    byte_out.data = cmd_r.y[7:0];
          4'd8:    byte_out.data = y_end[15:8];
          4'd9:    byte_out.data = y_end[7:0];
          default: begin
            byte_out.data = `LCD_CMD_RAMWR;
            byte_out.dc   = 1'b0;
          end
        endcase
      end
      S_PIXELS: begin
        byte_valid    = 1'b1;
        byte_out.data = toggle ? cmd_r.color[7:0] : cmd_r.color[15:8];
        byte_out.dc   = 1'b1;
      end
      default: byte_valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/lcd_init_rom.sv
// ST7789 start-up table
// command byte, flag byte (bit 7 delay follows, low bits arg count),
// arguments, then a delay exponent when flagged
`timescale 1ns/1ps
`default_nettype none
`include "lcd_defines.svh"

module lcd_init_rom
  import lcd_pkg::*;
(
  input  logic [3:0] rom_addr,
  output lcd_byte_t  rom_data
);

  always_comb begin
    case (rom_addr)
      // SWRESET, then wait
      4'd0:    rom_data = 8'h01;
      4'd1:    rom_data = 8'h80; // no args, delay
      4'd2:    rom_data = 8'h03; // 2^3 steps
      // SLPOUT, then wait
      4'd3:    rom_data = 8'h11;
      4'd4:    rom_data = 8'h80;
      4'd5:    rom_data = 8'h03;
      // COLMOD 16 bit/pixel
      4'd6:    rom_data = 8'h3A;
      4'd7:    rom_data = 8'h01; // one arg
      4'd8:    rom_data = 8'h55; // rgb565
      // MADCTL default orientation
      4'd9:    rom_data = 8'h36;
      4'd10:   rom_data = 8'h01;
      4'd11:   rom_data = 8'h00;
      // DISPON
      4'd12:   rom_data = 8'h29;
      4'd13:   rom_data = 8'h00; // no args, no delay
      default: rom_data = `LCD_CMD_NOP; // past end of table
    endcase
  end

endmodule

`default_nettype wire

// File: hw/lcd_cmd_fifo.sv
// Line command queue
// circular buffer with valid/ready on both sides, so new lines can
// wait while the current one is still being drawn
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_fifo
  import lcd_pkg::*;
#(
  parameter int DEPTH = 4 // number of queued commands
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      cmd_valid,
  input  line_cmd_t cmd,
  output logic      cmd_ready,
  output logic      q_valid,
  output line_cmd_t q_cmd,
  input  logic      q_ready,
  output logic      empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  line_cmd_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // step a pointer around the ring
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    ptr_next = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign cmd_ready = (count != CNT_W'(DEPTH)); // not full
  assign q_valid   = (count != '0);
  assign empty     = (count == '0);
  assign q_cmd     = mem[rd_ptr];              // head of queue
  assign push      = cmd_valid & cmd_ready;
  assign pop       = q_valid & q_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= cmd; // storage, no reset
  end

endmodule

`default_nettype wire

// File: hw/lcd_pkg.sv
// ST7789 line engine types
// coordinates, colors, line commands, serial words and sequencer states
`default_nettype none

package lcd_pkg;

  typedef logic [15:0] coord_t;    // pixel position or line length
  typedef logic [15:0] color_t;    // rgb565
  typedef logic [7:0]  lcd_byte_t; // one byte on the serial line

  // one line request, 65 bits
  typedef struct packed {
    coord_t x;        // start column
    coord_t y;        // start row
    coord_t len;      // pixels, 0 sends nothing
    color_t color;
    logic   vertical; // 0 horizontal, 1 vertical
  } line_cmd_t;

  // byte plus data/command select
  typedef struct packed {
    lcd_byte_t data;
    logic      dc;    // 0 command, 1 parameter or pixel
  } spi_word_t;

  typedef enum logic [2:0] {
    S_RESET_WAIT, // panel reset held low
    S_INIT_CMD,   // send start-up command byte
    S_INIT_FLAGS, // decode arg count and delay bit
    S_INIT_ARG,   // send start-up arguments
    S_INIT_DELAY, // timed wait after a command
    S_IDLE,       // wait for a line command
    S_WINDOW,     // caset/raset/ramwr bytes
    S_PIXELS      // color stream
  } seq_state_t;

endpackage

`default_nettype wire

// File: hw/lcd_defines.svh
// ST7789 line engine constants
// panel command codes, reset hold, delay step and start-up table size
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// clocks spi_resn stays low once reset is released
`define LCD_RESET_CYCLES 200

// one delay step in clocks, a rom exponent n waits this << n
`define LCD_DELAY_UNIT 4

// bytes in the start-up table (five entries)
`define LCD_ROM_SIZE 14

// ST7789 command codes
`define LCD_CMD_CASET 8'h2A // column address set
`define LCD_CMD_RASET 8'h2B // row address set
`define LCD_CMD_RAMWR 8'h2C // memory write
`define LCD_CMD_NOP   8'h00 // no operation

`endif
